// ==== src/rr_macros.svh ====
`ifndef RR_MACROS_SVH
`define RR_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Channel count and transaction field widths
////////////////////////////////////////////////////////////////////////////
`define RR_NUM_CH          2
`define RR_ADDR_W          8
`define RR_DATA_W          32

// Entries per channel log FIFO, a power of two
`define RR_LOG_FIFO_DEPTH  4

// Width of the record and replay entry counters
`define RR_CNT_W           16

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////
`define RR_CSR_ADDR_W      2
`define RR_CSR_MODE        0
`define RR_CSR_REC_CNT     1
`define RR_CSR_RPLY_CNT    2

`endif

// ==== src/rr_pkg.sv ====
`default_nettype none

`include "rr_macros.svh"

package rr_pkg;

  // Plain field widths
  typedef logic [`RR_ADDR_W-1:0]          rr_addr_t;
  typedef logic [`RR_DATA_W-1:0]          rr_data_t;
  typedef logic [$clog2(`RR_NUM_CH)-1:0]  rr_ch_id_t;
  typedef logic [`RR_CNT_W-1:0]           rr_cnt_t;
  typedef logic [`RR_CSR_ADDR_W-1:0]      rr_csr_addr_t;

  // One request on a channel
  typedef struct packed {
    rr_addr_t addr;
    rr_data_t data;
  } rr_txn_t;

  // Packed log stream entry, tagged with its channel
  typedef struct packed {
    rr_ch_id_t ch;
    rr_addr_t  addr;
    rr_data_t  data;
  } rr_log_entry_t;

  // Mode bits, record_en is bit 0 and replay_en is bit 1
  typedef struct packed {
    logic replay_en;
    logic record_en;
  } rr_mode_t;

  // Register write port, no handshake
  typedef struct packed {
    logic         valid;
    rr_csr_addr_t addr;
    rr_data_t     data;
  } rr_csr_wr_t;

  // Replay decoder holding register state
  typedef enum logic {
    DEC_EMPTY,
    DEC_FULL
  } rr_dec_state_t;

endpackage

`default_nettype wire

// ==== src/rr_channel_recorder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_channel_recorder #(
  // Channel id stamped into every log entry
  parameter rr_pkg::rr_ch_id_t CH_ID = '0
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  rr_pkg::rr_mode_t      i_mode,
  // Shell side
  input  logic                  i_sh_valid,
  input  rr_pkg::rr_txn_t       i_sh_txn,
  output logic                  o_sh_ready,
  // Replay side
  input  logic                  i_rp_valid,
  input  rr_pkg::rr_txn_t       i_rp_txn,
  output logic                  o_rp_ready,
  // User circuit side
  output logic                  o_cl_valid,
  output rr_pkg::rr_txn_t       o_cl_txn,
  input  logic                  i_cl_ready,
  // Log side toward the merger
  output logic                  o_log_valid,
  output rr_pkg::rr_log_entry_t o_log_entry,
  input  logic                  i_log_ready
);

  localparam int PTR_W = $clog2(`RR_LOG_FIFO_DEPTH);

  logic                  src_valid;
  rr_pkg::rr_txn_t       src_txn;
  logic                  src_ready;
  logic                  stall;
  logic                  fifo_full;
  logic                  push;
  logic                  pop;
  logic [PTR_W:0]        wr_ptr;
  logic [PTR_W:0]        rd_ptr;
  rr_pkg::rr_log_entry_t log_mem [`RR_LOG_FIFO_DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // Source select and pass-through
  ////////////////////////////////////////////////////////////////////////////
  // Replay mode hands the channel to the decoder
  assign src_valid = i_mode.replay_en ? i_rp_valid : i_sh_valid;
  assign src_txn   = i_mode.replay_en ? i_rp_txn   : i_sh_txn;

  // Hold the channel while the log has no room
  assign stall     = i_mode.record_en && fifo_full;
  assign src_ready = i_cl_ready && !stall;

  assign o_cl_valid = src_valid && !stall;
  assign o_cl_txn   = src_txn;

  // Only the selected source sees ready
  assign o_sh_ready = !i_mode.replay_en && src_ready;
  assign o_rp_ready = i_mode.replay_en && src_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Log FIFO
  ////////////////////////////////////////////////////////////////////////////
  // Log every user side transfer while recording
  assign push = i_mode.record_en && o_cl_valid && i_cl_ready;
  assign pop  = o_log_valid && i_log_ready;

  // Extra pointer bit tells full from empty
  assign fifo_full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign o_log_valid = (wr_ptr != rd_ptr);
  assign o_log_entry = log_mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge clk) begin
    if (push) begin
      log_mem[wr_ptr[PTR_W-1:0]] <= rr_pkg::rr_log_entry_t'{
        ch:   CH_ID,
        addr: src_txn.addr,
        data: src_txn.data
      };
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/rr_log_merger.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_log_merger (
  input  logic                                   clk,
  input  logic                                   rstn,
  // Channel logs
  input  logic [`RR_NUM_CH-1:0]                  i_log_valid,
  input  rr_pkg::rr_log_entry_t [`RR_NUM_CH-1:0] i_log_entry,
  output logic [`RR_NUM_CH-1:0]                  o_log_ready,
  // Packed record stream
  output logic                                   o_rec_valid,
  output rr_pkg::rr_log_entry_t                  o_rec_entry,
  input  logic                                   i_rec_ready,
  output logic                                   o_rec_pulse
);

  localparam rr_pkg::rr_ch_id_t LAST_CH = rr_pkg::rr_ch_id_t'(`RR_NUM_CH - 1);

  rr_pkg::rr_ch_id_t rr_ptr;
  rr_pkg::rr_ch_id_t grant_idx;
  logic              grant_valid;
  logic              load_en;

  // Output register takes a new entry when empty or draining
  assign load_en     = !o_rec_valid || i_rec_ready;
  assign o_rec_pulse = o_rec_valid && i_rec_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin pick starting at the pointer
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = rr_ptr;
    for (int k = 0; k < `RR_NUM_CH; k++) begin
      idx = int'(rr_ptr) + k;
      if (idx >= `RR_NUM_CH) idx = idx - `RR_NUM_CH;
      if (!grant_valid && i_log_valid[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = rr_pkg::rr_ch_id_t'(idx);
      end
    end
  end

  // Pop only the winner
  always_comb begin
    for (int i = 0; i < `RR_NUM_CH; i++) begin
      o_log_ready[i] = load_en && grant_valid && (grant_idx == rr_pkg::rr_ch_id_t'(i));
    end
  end

  // Pointer moves past the last winner
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rr_ptr      <= '0;
      o_rec_valid <= 1'b0;
    end else if (load_en) begin
      o_rec_valid <= grant_valid;
      if (grant_valid) rr_ptr <= (grant_idx == LAST_CH) ? '0 : grant_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en && grant_valid) o_rec_entry <= i_log_entry[grant_idx];
  end

endmodule

`default_nettype wire

// ==== src/rr_trace_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_trace_decoder (
  input  logic                             clk,
  input  logic                             rstn,
  // Packed replay stream
  input  logic                             i_rply_valid,
  input  rr_pkg::rr_log_entry_t            i_rply_entry,
  output logic                             o_rply_ready,
  // Per channel replay traffic
  output logic [`RR_NUM_CH-1:0]            o_rp_valid,
  output rr_pkg::rr_txn_t [`RR_NUM_CH-1:0] o_rp_txn,
  input  logic [`RR_NUM_CH-1:0]            i_rp_ready,
  output logic                             o_rply_pulse
);

  rr_pkg::rr_dec_state_t state;
  rr_pkg::rr_log_entry_t held;
  logic                  drain;
  logic                  accept;

  ////////////////////////////////////////////////////////////////////////////
  // Single entry hold keeps global log order
  ////////////////////////////////////////////////////////////////////////////
  // Held entry leaves when its own channel takes it
  assign drain  = (state == rr_pkg::DEC_FULL) && i_rp_ready[held.ch];

  // Next entry may enter in the same cycle the old one leaves
  assign o_rply_ready = (state == rr_pkg::DEC_EMPTY) || drain;
  assign accept       = i_rply_valid && o_rply_ready;
  assign o_rply_pulse = drain;

  // Valid only on the named channel, payload fans out to all
  always_comb begin
    for (int i = 0; i < `RR_NUM_CH; i++) begin
      o_rp_valid[i] = (state == rr_pkg::DEC_FULL) && (held.ch == rr_pkg::rr_ch_id_t'(i));
      o_rp_txn[i]   = rr_pkg::rr_txn_t'{addr: held.addr, data: held.data};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= rr_pkg::DEC_EMPTY;
    end else begin
      case (state)
        rr_pkg::DEC_EMPTY: if (accept) state <= rr_pkg::DEC_FULL;
        // Stay full when a drain and a refill coincide
        rr_pkg::DEC_FULL:  if (drain && !accept) state <= rr_pkg::DEC_EMPTY;
        default:           state <= rr_pkg::DEC_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) held <= i_rply_entry;
  end

endmodule

`default_nettype wire

// ==== src/rr_csrs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_csrs (
  input  logic                 clk,
  input  logic                 rstn,
  input  rr_pkg::rr_csr_wr_t   i_csr_wr,
  input  rr_pkg::rr_csr_addr_t i_csr_rd_addr,
  output rr_pkg::rr_data_t     o_csr_rd_data,
  output rr_pkg::rr_mode_t     o_mode,
  input  logic                 i_rec_pulse,
  input  logic                 i_rply_pulse
);

  rr_pkg::rr_cnt_t rec_cnt;
  rr_pkg::rr_cnt_t rply_cnt;
  logic            mode_wr;

  assign mode_wr = i_csr_wr.valid &&
                   (i_csr_wr.addr == rr_pkg::rr_csr_addr_t'(`RR_CSR_MODE));

  ////////////////////////////////////////////////////////////////////////////
  // Mode register and wrapping entry counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_mode        <= '0;
      rec_cnt       <= '0;
      rply_cnt      <= '0;
      o_csr_rd_data <= '0;
    end else begin
      if (mode_wr)      o_mode   <= rr_pkg::rr_mode_t'(i_csr_wr.data[1:0]);
      if (i_rec_pulse)  rec_cnt  <= rec_cnt + 1'b1;
      if (i_rply_pulse) rply_cnt <= rply_cnt + 1'b1;
      // Registered read, unused addresses give 0
      case (i_csr_rd_addr)
        rr_pkg::rr_csr_addr_t'(`RR_CSR_MODE):     o_csr_rd_data <= rr_pkg::rr_data_t'(o_mode);
        rr_pkg::rr_csr_addr_t'(`RR_CSR_REC_CNT):  o_csr_rd_data <= rr_pkg::rr_data_t'(rec_cnt);
        rr_pkg::rr_csr_addr_t'(`RR_CSR_RPLY_CNT): o_csr_rd_data <= rr_pkg::rr_data_t'(rply_cnt);
        default:                                  o_csr_rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/rr_wrapper.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_wrapper (
  input  logic                             clk,
  input  logic                             rstn,
  // Shell requests
  input  logic [`RR_NUM_CH-1:0]            i_sh_valid,
  input  rr_pkg::rr_txn_t [`RR_NUM_CH-1:0] i_sh_txn,
  output logic [`RR_NUM_CH-1:0]            o_sh_ready,
  // User circuit requests
  output logic [`RR_NUM_CH-1:0]            o_cl_valid,
  output rr_pkg::rr_txn_t [`RR_NUM_CH-1:0] o_cl_txn,
  input  logic [`RR_NUM_CH-1:0]            i_cl_ready,
  // Record stream out
  output logic                             o_rec_valid,
  output rr_pkg::rr_log_entry_t            o_rec_entry,
  input  logic                             i_rec_ready,
  // Replay stream in
  input  logic                             i_rply_valid,
  input  rr_pkg::rr_log_entry_t            i_rply_entry,
  output logic                             o_rply_ready,
  // Register port
  input  rr_pkg::rr_csr_wr_t               i_csr_wr,
  input  rr_pkg::rr_csr_addr_t             i_csr_rd_addr,
  output rr_pkg::rr_data_t                 o_csr_rd_data
);

  rr_pkg::rr_mode_t                       mode;
  logic [`RR_NUM_CH-1:0]                  log_valid;
  rr_pkg::rr_log_entry_t [`RR_NUM_CH-1:0] log_entry;
  logic [`RR_NUM_CH-1:0]                  log_ready;
  logic [`RR_NUM_CH-1:0]                  rp_valid;
  rr_pkg::rr_txn_t [`RR_NUM_CH-1:0]       rp_txn;
  logic [`RR_NUM_CH-1:0]                  rp_ready;
  logic                                   rec_pulse;
  logic                                   rply_pulse;

  ////////////////////////////////////////////////////////////////////////////
  // Per channel recorders
  ////////////////////////////////////////////////////////////////////////////
  rr_channel_recorder #(.CH_ID(rr_pkg::rr_ch_id_t'(0))) rec_ch0 (
    .clk, .rstn, .i_mode(mode),
    .i_sh_valid(i_sh_valid[0]), .i_sh_txn(i_sh_txn[0]), .o_sh_ready(o_sh_ready[0]),
    .i_rp_valid(rp_valid[0]), .i_rp_txn(rp_txn[0]), .o_rp_ready(rp_ready[0]),
    .o_cl_valid(o_cl_valid[0]), .o_cl_txn(o_cl_txn[0]), .i_cl_ready(i_cl_ready[0]),
    .o_log_valid(log_valid[0]), .o_log_entry(log_entry[0]), .i_log_ready(log_ready[0])
  );
  rr_channel_recorder #(.CH_ID(rr_pkg::rr_ch_id_t'(1))) rec_ch1 (
    .clk, .rstn, .i_mode(mode),
    .i_sh_valid(i_sh_valid[1]), .i_sh_txn(i_sh_txn[1]), .o_sh_ready(o_sh_ready[1]),
    .i_rp_valid(rp_valid[1]), .i_rp_txn(rp_txn[1]), .o_rp_ready(rp_ready[1]),
    .o_cl_valid(o_cl_valid[1]), .o_cl_txn(o_cl_txn[1]), .i_cl_ready(i_cl_ready[1]),
    .o_log_valid(log_valid[1]), .o_log_entry(log_entry[1]), .i_log_ready(log_ready[1])
  );

  // Channel logs into one record stream
  rr_log_merger merger (
    .clk, .rstn,
    .i_log_valid(log_valid), .i_log_entry(log_entry), .o_log_ready(log_ready),
    .o_rec_valid, .o_rec_entry, .i_rec_ready, .o_rec_pulse(rec_pulse)
  );

  // Replay stream back onto the channels
  rr_trace_decoder decoder (
    .clk, .rstn,
    .i_rply_valid, .i_rply_entry, .o_rply_ready,
    .o_rp_valid(rp_valid), .o_rp_txn(rp_txn), .i_rp_ready(rp_ready),
    .o_rply_pulse(rply_pulse)
  );

  // Mode bits and entry counters
  rr_csrs csrs (
    .clk, .rstn, .i_csr_wr, .i_csr_rd_addr, .o_csr_rd_data,
    .o_mode(mode), .i_rec_pulse(rec_pulse), .i_rply_pulse(rply_pulse)
  );

endmodule

`default_nettype wire

// ==== verification/rr_wrapper_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_wrapper_assertions (
  input logic                  clk,
  input logic                  rstn,
  input rr_pkg::rr_csr_wr_t    i_csr_wr,
  input logic [`RR_NUM_CH-1:0] i_sh_ready,
  input logic                  i_rply_valid,
  input logic                  i_rec_valid,
  input rr_pkg::rr_log_entry_t i_rec_entry,
  input logic                  i_rec_ready
);

  logic mode_wr;
  logic replay_mode;

  // Replay bit as written through the register port, bit 1 of the mode register
  assign mode_wr = i_csr_wr.valid &&
                   (i_csr_wr.addr == rr_pkg::rr_csr_addr_t'(`RR_CSR_MODE));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      replay_mode <= 1'b0;
    end else if (mode_wr) begin
      replay_mode <= i_csr_wr.data[1];
    end
  end

  // Record payload holds while the consumer stalls
  rec_stable: assert property (@(posedge clk) disable iff (!rstn)
    i_rec_valid && !i_rec_ready |=> i_rec_valid && $stable(i_rec_entry))
    else $error("record entry changed or vanished under back-pressure");

  // Decoder owns the channels during replay
  shell_blocked: assert property (@(posedge clk) disable iff (!rstn)
    replay_mode && i_rply_valid |-> i_sh_ready == '0)
    else $error("shell accepted while a replay was pending");

  // Record stream idle right after reset
  rec_idle_after_reset: assert property (@(posedge clk) !rstn |=> !i_rec_valid)
    else $error("record valid set after reset");

endmodule

`default_nettype wire

// ==== verification/rr_wrapper_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rr_macros.svh"

module rr_wrapper_tb;

  localparam int NCH     = `RR_NUM_CH;
  localparam int TIMEOUT = 2000;

  logic                             clk;
  logic                             rstn;
  logic [`RR_NUM_CH-1:0]            i_sh_valid;
  rr_pkg::rr_txn_t [`RR_NUM_CH-1:0] i_sh_txn;
  logic [`RR_NUM_CH-1:0]            o_sh_ready;
  logic [`RR_NUM_CH-1:0]            o_cl_valid;
  rr_pkg::rr_txn_t [`RR_NUM_CH-1:0] o_cl_txn;
  logic [`RR_NUM_CH-1:0]            i_cl_ready;
  logic                             o_rec_valid;
  rr_pkg::rr_log_entry_t            o_rec_entry;
  logic                             i_rec_ready;
  logic                             i_rply_valid;
  rr_pkg::rr_log_entry_t            i_rply_entry;
  logic                             o_rply_ready;
  rr_pkg::rr_csr_wr_t               i_csr_wr;
  rr_pkg::rr_csr_addr_t             i_csr_rd_addr;
  rr_pkg::rr_data_t                 o_csr_rd_data;

  // Expected entries per channel and in global replay order
  rr_pkg::rr_log_entry_t exp_cl [NCH][$];
  rr_pkg::rr_log_entry_t exp_rec [NCH][$];
  rr_pkg::rr_log_entry_t exp_rply [$];
  logic                  record_on;
  logic                  replay_on;
  logic [NCH-1:0]        sh_fire;
  logic                  rply_fire;
  logic                  timed_out;
  int                    errors;
  int                    checks;
  int                    cl_xfers;
  int                    rec_sent;
  int                    rply_sent;
  integer                seed;

  rr_wrapper rr_wrapper_inst (.*);

  bind rr_wrapper rr_wrapper_assertions assertions_inst (
    .clk, .rstn, .i_csr_wr, .i_sh_ready(o_sh_ready), .i_rply_valid,
    .i_rec_valid(o_rec_valid), .i_rec_entry(o_rec_entry), .i_rec_ready
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference function and compare
  ////////////////////////////////////////////////////////////////////////////
  // Expected entry is the channel id plus the request as issued
  function automatic rr_pkg::rr_log_entry_t model_entry(input int ch, input rr_pkg::rr_txn_t t);
    rr_pkg::rr_log_entry_t e;
    e.ch   = rr_pkg::rr_ch_id_t'(ch);
    e.addr = t.addr;
    e.data = t.data;
    return e;
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL @%0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input int cyc, input string what);
    if (cyc > TIMEOUT && !timed_out) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout while waiting for %s at %0t ns", what, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checker sampling on the rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    rr_pkg::rr_log_entry_t e;
    if (rstn) begin
      for (int c = 0; c < NCH; c++) begin
        if (o_cl_valid[c] && i_cl_ready[c]) begin
          cl_xfers++;
          if (replay_on ? exp_rply.size() == 0 : exp_cl[c].size() == 0) begin
            errors++;
            $display("Unexpected user-side transfer on channel %0d at %0t ns", c, $time);
          end else begin
            if (replay_on) begin
              e = exp_rply.pop_front();
              // Replay order decides the channel
              compare("user channel", c, e.ch);
            end else begin
              e = exp_cl[c].pop_front();
            end
            compare("user request", o_cl_txn[c], {e.addr, e.data});
          end
        end
      end
      // Any record entry must have been expected
      if (o_rec_valid && exp_rec[o_rec_entry.ch].size() == 0) begin
        errors++;
        $display("Record entry with nothing outstanding at %0t ns", $time);
      end else if (o_rec_valid && i_rec_ready) begin
        compare("record entry", o_rec_entry, exp_rec[o_rec_entry.ch].pop_front());
      end
    end
    // Handshakes seen by the stimulus on the next falling edge
    sh_fire   <= i_sh_valid & o_sh_ready;
    rply_fire <= i_rply_valid && o_rply_ready;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  // Random readies or a held record port with the user side open
  task automatic drive_ready(input logic hold_rec);
    i_cl_ready  = hold_rec ? '1 : NCH'($random(seed));
    i_rec_ready = hold_rec ? 1'b0 : 1'($random(seed));
  endtask

  task automatic drive_shell(input int n, input int hold);
    int sent [NCH];
    int total;
    int cyc;
    int base;
    total = 0;
    cyc   = 0;
    base  = cl_xfers;
    foreach (sent[c]) sent[c] = 0;
    while ((total < n * NCH || i_sh_valid != '0) && !timed_out) begin
      @(negedge clk);
      cyc++;
      note_timeout(cyc, "shell traffic");
      drive_ready(cyc <= hold);
      // FIFO depth per channel plus the merger output register
      if (hold > 0 && cyc == hold)
        compare("transfers while record held", cl_xfers - base, 2 * `RR_LOG_FIFO_DEPTH + 1);
      for (int c = 0; c < NCH; c++) begin
        if (sh_fire[c]) i_sh_valid[c] = 1'b0;
        if (!i_sh_valid[c] && sent[c] < n && $random(seed) % 2 == 0) begin
          i_sh_txn[c].addr = 8'($random(seed));
          i_sh_txn[c].data = $random(seed);
          i_sh_valid[c]    = 1'b1;
          exp_cl[c].push_back(model_entry(c, i_sh_txn[c]));
          if (record_on) begin
            exp_rec[c].push_back(model_entry(c, i_sh_txn[c]));
            rec_sent++;
          end
          sent[c]++;
          total++;
        end
      end
    end
  endtask

  task automatic drive_replay(input int n);
    rr_pkg::rr_txn_t t;
    int              sent;
    int              cyc;
    sent = 0;
    cyc  = 0;
    // Shell keeps asking and must be ignored
    i_sh_valid = '1;
    while ((sent < n || i_rply_valid) && !timed_out) begin
      @(negedge clk);
      cyc++;
      note_timeout(cyc, "replay traffic");
      drive_ready(1'b0);
      if (rply_fire) i_rply_valid = 1'b0;
      if (!i_rply_valid && sent < n && $random(seed) % 2 == 0) begin
        t.addr       = 8'($random(seed));
        t.data       = $random(seed);
        i_rply_entry = model_entry(int'(1'($random(seed))), t);
        i_rply_valid = 1'b1;
        exp_rply.push_back(model_entry(i_rply_entry.ch, t));
        if (record_on) begin
          exp_rec[i_rply_entry.ch].push_back(model_entry(i_rply_entry.ch, t));
          rec_sent++;
        end
        rply_sent++;
        sent++;
      end
    end
    i_sh_valid = '0;
  endtask

  // Open all readies until the model has nothing outstanding
  task automatic wait_drain();
    int cyc;
    cyc         = 0;
    i_cl_ready  = '1;
    i_rec_ready = 1'b1;
    while (exp_rec[0].size() + exp_rec[1].size() + exp_rply.size() != 0 && !timed_out) begin
      @(negedge clk);
      cyc++;
      note_timeout(cyc, "outstanding entries");
    end
    @(negedge clk);
  endtask

  task automatic write_mode(input logic rec, input logic rply);
    i_csr_wr.valid = 1'b1;
    i_csr_wr.addr  = rr_pkg::rr_csr_addr_t'(`RR_CSR_MODE);
    i_csr_wr.data  = rr_pkg::rr_data_t'({rply, rec});
    @(negedge clk);
    i_csr_wr.valid = 1'b0;
    record_on      = rec;
    replay_on      = rply;
  endtask

  // Read data follows the address by one cycle
  task automatic check_csr(input int addr, input int exp, input string what);
    i_csr_rd_addr = rr_pkg::rr_csr_addr_t'(addr);
    @(negedge clk);
    compare(what, o_csr_rd_data, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    seed          = 32'h1ac8_27ff;
    clk           = 1'b0;
    rstn          = 1'b0;
    i_sh_valid    = '0;
    i_sh_txn      = '0;
    i_cl_ready    = '0;
    i_rec_ready   = 1'b0;
    i_rply_valid  = 1'b0;
    i_rply_entry  = '0;
    i_csr_wr      = '0;
    i_csr_rd_addr = '0;
    record_on     = 1'b0;
    replay_on     = 1'b0;
    timed_out     = 1'b0;
    errors        = 0;
    checks        = 0;
    cl_xfers      = 0;
    rec_sent      = 0;
    rply_sent     = 0;
    repeat (8) @(negedge clk);
    rstn = 1'b1;
    check_csr(`RR_CSR_MODE, 0, "mode after reset");
    // Pass-through with nothing recorded
    drive_shell(20, 0);
    wait_drain();
    // Record with random back-pressure
    write_mode(1'b1, 1'b0);
    check_csr(`RR_CSR_MODE, 1, "mode readback");
    drive_shell(20, 0);
    wait_drain();
    check_csr(`RR_CSR_REC_CNT, rec_sent, "record count");
    // Record port held low until the FIFOs fill
    drive_shell(8, 40);
    wait_drain();
    check_csr(`RR_CSR_REC_CNT, rec_sent, "record count after stall");
    // Replay only
    write_mode(1'b0, 1'b1);
    drive_replay(16);
    wait_drain();
    // Record during replay
    write_mode(1'b1, 1'b1);
    drive_replay(16);
    wait_drain();
    check_csr(`RR_CSR_RPLY_CNT, rply_sent, "replay count");
    check_csr(`RR_CSR_REC_CNT, rec_sent, "record count after replay");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rr_wrapper.f ====
+incdir+src
src/rr_pkg.sv
src/rr_channel_recorder.sv
src/rr_log_merger.sv
src/rr_trace_decoder.sv
src/rr_csrs.sv
src/rr_wrapper.sv
verification/rr_wrapper_assertions.sv
verification/rr_wrapper_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module rr_wrapper_tb -f rr_wrapper.f
	out=$$(./obj_dir/Vrr_wrapper_tb); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
